/* common/hostPkg.sv */
package hostPkg;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		HALTED,
		FAULT
	} seqStateT;

	typedef enum logic [1:0] {
		REG_CTRL,
		REG_STATUS,
		REGION_IMEM,
		REGION_DMEM
	} apbRegionT;

endpackage

/* common/isaPkg.sv */
package isaPkg;

	typedef enum logic [3:0] {
		OP_LDUR,
		OP_STUR,
		OP_ADD,
		OP_ADDI,
		OP_SUB,
		OP_AND,
		OP_ORR,
		OP_CBZ,
		OP_CBNZ,
		OP_B,
		OP_HALT,
		OP_ILLEGAL
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_ORR   = 3'd3,
		ALU_PASSB = 3'd4
	} aluFuncT;

	// Second ALU operand source
	typedef enum logic [1:0] {
		SRC_REG  = 2'b00,
		SRC_DIMM = 2'b01, // 9-bit D-format offset
		SRC_IIMM = 2'b10  // 12-bit I-format immediate
	} aluSrcT;

endpackage

/* common/legv8_defines.svh */
`ifndef LEGV8_DEFINES_SVH
`define LEGV8_DEFINES_SVH

// Datapath and APB word width
`define DATA_WIDTH 32
`define INST_WIDTH 32

// Memory depths in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`define REG_COUNT 32

`define APB_ADDR_WIDTH 12

`endif

/* datapath/alu.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  isaPkg::aluFuncT        func,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   zero
);
	import isaPkg::*;

	always_comb begin
		case (func)
			ALU_ADD:   result = a + b;
			ALU_SUB:   result = a - b;
			ALU_AND:   result = a & b;
			ALU_ORR:   result = a | b;
			ALU_PASSB: result = b; // Branch compare on Rt
			default:   result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module regFile (
	input  logic                           clk,
	input  logic [$clog2(`REG_COUNT)-1:0]  readAddrA,
	input  logic [$clog2(`REG_COUNT)-1:0]  readAddrB,
	input  logic [$clog2(`REG_COUNT)-1:0]  writeAddr,
	input  logic [`DATA_WIDTH-1:0]         writeData,
	input  logic                           writeEn,
	output logic [`DATA_WIDTH-1:0]         readDataA,
	output logic [`DATA_WIDTH-1:0]         readDataB
);
	localparam int addrW = $clog2(`REG_COUNT);
	localparam logic [addrW-1:0] xzr = addrW'(`REG_COUNT - 1);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	assign readDataA = (readAddrA == xzr) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == xzr) ? '0 : regs[readAddrB];

	always_ff @(posedge clk) begin
		if (writeEn && writeAddr != xzr) begin // XZR discards writes
			regs[writeAddr] <= writeData;
		end
	end

endmodule

/* legv8Cpu.f */
+incdir+common
common/isaPkg.sv
common/hostPkg.sv
source/cpuControl.sv
source/sequencer.sv
source/programCounter.sv
datapath/regFile.sv
datapath/alu.sv
source/cpuMemories.sv
source/legv8Top.sv
tb/tbLegv8.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbLegv8 \
	-f legv8Cpu.f -o simLegv8 || exit 1
out="$(./obj_dir/simLegv8 2>&1)"
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* source/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
	input  logic [10:0]      opField,
	output isaPkg::opcodeT   opcode,
	output logic             reg2Loc,
	output logic             uncondBranch,
	output logic             branchZero,
	output logic             branchNonZero,
	output logic             memRead,
	output logic             memToReg,
	output logic             memWrite,
	output logic             regWriteEn,
	output isaPkg::aluSrcT   aluSrc,
	output isaPkg::aluFuncT  aluFunc,
	output logic             illegal
);
	import isaPkg::*;

	always_comb begin
		opcode = OP_ILLEGAL;
		reg2Loc = 1'b0;
		uncondBranch = 1'b0;
		branchZero = 1'b0;
		branchNonZero = 1'b0;
		memRead = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		regWriteEn = 1'b0;
		aluSrc = SRC_REG;
		aluFunc = ALU_ADD;
		illegal = 1'b0;
		if (opField == 11'b11111000010) begin // LDUR
			opcode = OP_LDUR;
			memRead = 1'b1;
			memToReg = 1'b1;
			aluSrc = SRC_DIMM;
			regWriteEn = 1'b1;
		end else if (opField == 11'b11111000000) begin // STUR
			opcode = OP_STUR;
			reg2Loc = 1'b1; // Rt on read port B
			memWrite = 1'b1;
			aluSrc = SRC_DIMM;
		end else if (opField == 11'b10001011000) begin
			opcode = OP_ADD;
			regWriteEn = 1'b1;
		end else if (opField[10:1] == 10'b1001000100) begin
			opcode = OP_ADDI;
			aluSrc = SRC_IIMM;
			regWriteEn = 1'b1;
		end else if (opField == 11'b11001011000) begin
			opcode = OP_SUB;
			aluFunc = ALU_SUB;
			regWriteEn = 1'b1;
		end else if (opField == 11'b10001010000) begin
			opcode = OP_AND;
			aluFunc = ALU_AND;
			regWriteEn = 1'b1;
		end else if (opField == 11'b10101010000) begin
			opcode = OP_ORR;
			aluFunc = ALU_ORR;
			regWriteEn = 1'b1;
		end else if (opField[10:3] == 8'b10110100) begin
			opcode = OP_CBZ;
			reg2Loc = 1'b1;
			branchZero = 1'b1;
			aluFunc = ALU_PASSB; // Test Rt through the ALU
		end else if (opField[10:3] == 8'b10110101) begin
			opcode = OP_CBNZ;
			reg2Loc = 1'b1;
			branchNonZero = 1'b1;
			aluFunc = ALU_PASSB;
		end else if (opField[10:5] == 6'b000101) begin
			opcode = OP_B;
			uncondBranch = 1'b1;
			aluFunc = ALU_PASSB;
		end else if (opField == 11'b11111111111) begin
			opcode = OP_HALT;
		end else begin
			illegal = 1'b1;
		end
	end

endmodule

/* source/cpuMemories.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module cpuMemories (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pSel,
	input  logic                       pEnable,
	input  logic                       pWrite,
	input  logic [`APB_ADDR_WIDTH-1:0] pAddr,
	input  logic [`DATA_WIDTH-1:0]     pWdata,
	output logic [`DATA_WIDTH-1:0]     pRdata,
	output logic                       pReady,
	output logic                       pSlvErr,
	input  logic [`DATA_WIDTH-1:0]     pc,
	input  logic [`DATA_WIDTH-1:0]     dataAddr,
	input  logic [`DATA_WIDTH-1:0]     storeData,
	input  logic                       dmemWrite,
	input  hostPkg::seqStateT          state,
	output logic [`INST_WIDTH-1:0]     instruction,
	output logic [`DATA_WIDTH-1:0]     loadData,
	output logic                       start
);
	import hostPkg::*;

	localparam int imemAddrW = $clog2(`IMEM_DEPTH);
	localparam int dmemAddrW = $clog2(`DMEM_DEPTH);

	logic [`INST_WIDTH-1:0] imem [`IMEM_DEPTH];
	logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];
	apbRegionT region;
	logic mapped;
	logic running;
	logic accessErr;
	logic hostWrite;
	logic [`DATA_WIDTH-1:0] status;

	always_comb begin
		region = REG_CTRL;
		mapped = 1'b0;
		case (pAddr[11:10])
			2'b00: begin
				region = pAddr[2] ? REG_STATUS : REG_CTRL;
				mapped = (pAddr[9:3] == '0) && (pAddr[1:0] == '0);
			end
			2'b01: begin
				region = REGION_IMEM;
				mapped = (pAddr[9:2] < `IMEM_DEPTH) && (pAddr[1:0] == '0);
			end
			2'b10: begin
				region = REGION_DMEM;
				mapped = (pAddr[9:2] < `DMEM_DEPTH) && (pAddr[1:0] == '0);
			end
			default: mapped = 1'b0;
		endcase
	end

	assign running = !(state inside {IDLE, HALTED, FAULT});
	// Memories belong to the core while it runs
	assign accessErr = !mapped || (running && (region == REGION_IMEM || region == REGION_DMEM));
	assign hostWrite = pSel && pEnable && pWrite && !accessErr;
	assign pSlvErr = pSel && pEnable && accessErr;
	assign pReady = 1'b1;

	assign status = {{(`DATA_WIDTH-16){1'b0}}, pc[9:2], 5'b0,
		state == FAULT, state == HALTED, running};

	always_comb begin
		pRdata = '0;
		if (pSel && !pWrite && !accessErr) begin
			case (region)
				REG_STATUS:  pRdata = status;
				REGION_IMEM: pRdata = imem[pAddr[imemAddrW+1:2]];
				REGION_DMEM: pRdata = dmem[pAddr[dmemAddrW+1:2]];
				default:     pRdata = '0; // CTRL is write only
			endcase
		end
	end

	assign instruction = imem[pc[imemAddrW+1:2]];
	assign loadData = dmem[dataAddr[dmemAddrW+1:2]];

	always_ff @(posedge clk) begin
		if (hostWrite && region == REGION_IMEM) begin
			imem[pAddr[imemAddrW+1:2]] <= pWdata;
		end
		if (hostWrite && region == REGION_DMEM) begin
			dmem[pAddr[dmemAddrW+1:2]] <= pWdata;
		end else if (dmemWrite) begin
			dmem[dataAddr[dmemAddrW+1:2]] <= storeData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
		end else begin
			start <= hostWrite && region == REG_CTRL && pWdata[0];
		end
	end

endmodule

/* source/legv8Top.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module legv8Top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pSel,
	input  logic                       pEnable,
	input  logic                       pWrite,
	input  logic [`APB_ADDR_WIDTH-1:0] pAddr,
	input  logic [`DATA_WIDTH-1:0]     pWdata,
	output logic [`DATA_WIDTH-1:0]     pRdata,
	output logic                       pReady,
	output logic                       pSlvErr
);
	import isaPkg::*;
	import hostPkg::*;

	logic [`INST_WIDTH-1:0] instruction;
	logic [`INST_WIDTH-1:0] instReg;
	opcodeT opcode;
	aluFuncT aluFunc;
	aluSrcT aluSrc;
	seqStateT state;
	logic reg2Loc, uncondBranch, branchZero, branchNonZero;
	logic memRead, memToReg, memWrite, regWriteEn, illegal;
	logic irLoad, pcStep, pcBranch, pcClear, dmemWrite, regWrite, start, aluZero;
	logic [$clog2(`REG_COUNT)-1:0] readAddrB;
	logic [`DATA_WIDTH-1:0] pc, branchOffset, readDataA, readDataB;
	logic [`DATA_WIDTH-1:0] aluB, aluResult, loadData, wbData;

	always_ff @(posedge clk) begin
		if (irLoad) begin
			instReg <= instruction;
		end
	end

	assign readAddrB = reg2Loc ? instReg[4:0] : instReg[20:16]; // Rt or Rm

	always_comb begin
		case (aluSrc)
			SRC_DIMM: aluB = {{(`DATA_WIDTH-9){instReg[20]}}, instReg[20:12]};
			SRC_IIMM: aluB = {{(`DATA_WIDTH-12){1'b0}}, instReg[21:10]};
			default:  aluB = readDataB;
		endcase
	end

	// B uses imm26, CBZ and CBNZ use imm19
	assign branchOffset = uncondBranch ? {{(`DATA_WIDTH-26){instReg[25]}}, instReg[25:0]}
		: {{(`DATA_WIDTH-19){instReg[23]}}, instReg[23:5]};
	assign wbData = (memRead && memToReg) ? loadData : aluResult;

	cpuControl i_cpuControl (
		.opField(instReg[31:21]), .opcode(opcode), .reg2Loc(reg2Loc),
		.uncondBranch(uncondBranch), .branchZero(branchZero), .branchNonZero(branchNonZero),
		.memRead(memRead), .memToReg(memToReg), .memWrite(memWrite),
		.regWriteEn(regWriteEn), .aluSrc(aluSrc), .aluFunc(aluFunc), .illegal(illegal)
	);

	sequencer i_sequencer (
		.clk(clk), .rst(rst), .start(start), .opcode(opcode), .illegal(illegal),
		.uncondBranch(uncondBranch), .branchZero(branchZero), .branchNonZero(branchNonZero),
		.memWrite(memWrite), .regWriteEn(regWriteEn), .aluZero(aluZero), .state(state),
		.irLoad(irLoad), .pcStep(pcStep), .pcBranch(pcBranch), .pcClear(pcClear),
		.dmemWrite(dmemWrite), .regWrite(regWrite)
	);

	programCounter i_programCounter (
		.clk(clk), .rst(rst), .clear(pcClear), .step(pcStep), .branch(pcBranch),
		.branchOffset(branchOffset), .pc(pc)
	);

	regFile i_regFile (
		.clk(clk), .readAddrA(instReg[9:5]), .readAddrB(readAddrB),
		.writeAddr(instReg[4:0]), .writeData(wbData), .writeEn(regWrite),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	alu i_alu (
		.a(readDataA), .b(aluB), .func(aluFunc), .result(aluResult), .zero(aluZero)
	);

	cpuMemories i_cpuMemories (
		.clk(clk), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady),
		.pSlvErr(pSlvErr), .pc(pc), .dataAddr(aluResult), .storeData(readDataB),
		.dmemWrite(dmemWrite), .state(state), .instruction(instruction),
		.loadData(loadData), .start(start)
	);

endmodule

/* source/programCounter.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module programCounter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          clear,
	input  logic                          step,
	input  logic                          branch,
	input  logic signed [`DATA_WIDTH-1:0] branchOffset,
	output logic        [`DATA_WIDTH-1:0] pc
);
	localparam logic [`DATA_WIDTH-1:0] wordBytes = 4;

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			pc <= '0;
		end else if (step) begin
			pc <= pc + wordBytes;
		end else if (branch) begin
			pc <= pc + (branchOffset <<< 2); // Word offset to bytes
		end
	end

endmodule

/* source/sequencer.sv */
`timescale 1ns/1ps

module sequencer (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  isaPkg::opcodeT    opcode,
	input  logic              illegal,
	input  logic              uncondBranch,
	input  logic              branchZero,
	input  logic              branchNonZero,
	input  logic              memWrite,
	input  logic              regWriteEn,
	input  logic              aluZero,
	output hostPkg::seqStateT state,
	output logic              irLoad,
	output logic              pcStep,
	output logic              pcBranch,
	output logic              pcClear,
	output logic              dmemWrite,
	output logic              regWrite
);
	import isaPkg::*;
	import hostPkg::*;

	seqStateT nextState;
	logic stopped;
	logic taken;

	assign stopped = state inside {IDLE, HALTED, FAULT};
	assign taken = uncondBranch || (branchZero && aluZero) || (branchNonZero && !aluZero);

	always_comb begin
		nextState = state;
		case (state)
			IDLE, HALTED, FAULT: begin
				if (start) begin
					nextState = FETCH;
				end
			end
			FETCH: nextState = DECODE;
			DECODE: begin
				if (illegal) begin
					nextState = FAULT;
				end else if (opcode == OP_HALT) begin
					nextState = HALTED; // PC stays on the HALT word
				end else begin
					nextState = EXECUTE;
				end
			end
			EXECUTE: nextState = MEMORY;
			MEMORY: nextState = WRITEBACK;
			WRITEBACK: nextState = FETCH;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	assign irLoad = (state == FETCH);
	assign pcStep = (state == EXECUTE) && !taken;
	assign pcBranch = (state == EXECUTE) && taken;
	assign pcClear = start && stopped; // Restart from word 0
	assign dmemWrite = (state == MEMORY) && memWrite;
	assign regWrite = (state == WRITEBACK) && regWriteEn;

	branchOnlyForBranchOps: assert property (@(posedge clk) disable iff (rst)
		pcBranch |-> opcode inside {OP_B, OP_CBZ, OP_CBNZ});
	storeOnlyForStur: assert property (@(posedge clk) disable iff (rst)
		dmemWrite |-> opcode == OP_STUR);
	regWriteOnlyForResults: assert property (@(posedge clk) disable iff (rst)
		regWrite |-> opcode inside {OP_LDUR, OP_ADD, OP_ADDI, OP_SUB, OP_AND, OP_ORR});
	illegalNoWrite: assert property (@(posedge clk) disable iff (rst)
		illegal |-> !memWrite && !regWriteEn);

endmodule

/* tb/tbLegv8.sv */
`timescale 1ns/1ps
`include "legv8_defines.svh"

module tbLegv8;
	import isaPkg::*;
	import hostPkg::*;

	localparam logic [10:0] opAdd = 11'b10001011000;
	localparam logic [10:0] opSub = 11'b11001011000;
	localparam logic [10:0] opAnd = 11'b10001010000;
	localparam logic [10:0] opOrr = 11'b10101010000;
	localparam logic [4:0] xzr = 5'd31;
	localparam logic [`INST_WIDTH-1:0] haltWord = 32'hFFE0_0000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic pSel = 1'b0;
	logic pEnable = 1'b0;
	logic pWrite = 1'b0;
	logic [`APB_ADDR_WIDTH-1:0] pAddr = '0;
	logic [`DATA_WIDTH-1:0] pWdata = '0;
	logic [`DATA_WIDTH-1:0] pRdata;
	logic pReady;
	logic pSlvErr;
	int cycleCount = 0;
	int deadline = 10; // Covers reset
	int startCycle = 0;
	int sampleCycle = 0; // Cycle of the last APB access-phase sample
	integer seed = 32'h8150_884a;
	logic [`INST_WIDTH-1:0] prog[$];

	legv8Top i_dut (
		.clk(clk), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	// Instruction encoders
	function automatic logic [`INST_WIDTH-1:0] ldur(input logic [4:0] rt, rn,
			input logic [8:0] imm);
		return {11'b11111000010, imm, 2'b00, rn, rt};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] stur(input logic [4:0] rt, rn,
			input logic [8:0] imm);
		return {11'b11111000000, imm, 2'b00, rn, rt};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] rType(input logic [10:0] opc,
			input logic [4:0] rd, rn, rm);
		return {opc, rm, 6'b0, rn, rd};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] addi(input logic [4:0] rd, rn,
			input logic [11:0] imm);
		return {10'b1001000100, imm, rn, rd};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] condBranch(input logic nonZero,
			input logic [4:0] rt, input logic [18:0] offset);
		return {7'b1011010, nonZero, offset, rt};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] branch(input logic [25:0] offset);
		return {6'b000101, offset};
	endfunction

	function automatic logic [`APB_ADDR_WIDTH-1:0] addrOf(input apbRegionT region, input int word);
		case (region)
			REG_CTRL: return 12'h000;
			REG_STATUS: return 12'h004;
			REGION_IMEM: return 12'h400 + 12'(word * 4);
			default: return 12'h800 + 12'(word * 4);
		endcase
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] fillWord(input int word);
		return {20'hC0DE0, addrOf(REGION_DMEM, word)}; // Unique per address
	endfunction

	task automatic failCheck(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1, "first mismatch ends the run");
	endtask

	task automatic checkWord(input string what, input logic [`DATA_WIDTH-1:0] got, exp);
		if (got !== exp) begin
			failCheck($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkState(input string what, input seqStateT got, exp);
		if (got !== exp) begin
			failCheck($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
		end
	endtask

	task automatic checkErr(input string what, input logic got, exp);
		if (got !== exp) begin
			failCheck($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic apbTransfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
			input logic [`DATA_WIDTH-1:0] wdata, output logic [`DATA_WIDTH-1:0] rdata,
			output logic err);
		@(negedge clk);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWdata = wdata;
		@(negedge clk);
		pEnable = 1'b1; // Access phase
		#1;
		rdata = pRdata;
		err = pSlvErr;
		sampleCycle = cycleCount;
		checkErr("pReady", pReady, 1'b1);
		@(negedge clk);
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr,
			input logic [`DATA_WIDTH-1:0] data, output logic err);
		logic [`DATA_WIDTH-1:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr,
			output logic [`DATA_WIDTH-1:0] data, output logic err);
		apbTransfer(1'b0, addr, '0, data, err);
	endtask

	task automatic hostWrite(input logic [`APB_ADDR_WIDTH-1:0] addr,
			input logic [`DATA_WIDTH-1:0] data);
		logic err;
		apbWrite(addr, data, err);
		checkErr($sformatf("pSlvErr on write to %h", addr), err, 1'b0);
	endtask

	task automatic hostRead(input logic [`APB_ADDR_WIDTH-1:0] addr,
			output logic [`DATA_WIDTH-1:0] data);
		logic err;
		apbRead(addr, data, err);
		checkErr($sformatf("pSlvErr on read of %h", addr), err, 1'b0);
	endtask

	task automatic readState(output seqStateT st, output logic [`DATA_WIDTH-1:0] pcIndex);
		logic [`DATA_WIDTH-1:0] status;
		hostRead(addrOf(REG_STATUS, 0), status);
		pcIndex = '0;
		pcIndex[7:0] = status[15:8];
		case (status[2:0])
			3'b000: st = IDLE;
			3'b001: st = FETCH; // Any running step reads back as FETCH
			3'b010: st = HALTED;
			3'b100: st = FAULT;
			default: begin
				st = IDLE;
				failCheck($sformatf("STATUS flags %b are not a valid combination", status[2:0]));
			end
		endcase
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			hostWrite(addrOf(REGION_IMEM, i), prog[i]);
		end
		deadline += 5 * prog.size();
	endtask

	task automatic startProgram();
		hostWrite(addrOf(REG_CTRL, 0), 32'd1);
		startCycle = cycleCount;
	endtask

	task automatic waitDone(output seqStateT st, output logic [`DATA_WIDTH-1:0] pcIndex,
			output int elapsed);
		do begin
			readState(st, pcIndex);
		end while (st == FETCH);
		elapsed = sampleCycle - startCycle; // Up to the read that saw the stop
	endtask

	task automatic runUntilDone(output seqStateT st, output logic [`DATA_WIDTH-1:0] pcIndex,
			output int elapsed);
		startProgram();
		waitDone(st, pcIndex, elapsed);
	endtask

	task automatic beginTest(input string name);
		$display("Test: %s", name);
		deadline += 200; // APB traffic of one test
		prog = {};
	endtask

	task automatic resetStatusTest();
		logic [`DATA_WIDTH-1:0] status;
		beginTest("status after reset");
		hostRead(addrOf(REG_STATUS, 0), status);
		checkWord("STATUS after reset", status, '0);
	endtask

	task automatic arithmeticTest();
		logic [`DATA_WIDTH-1:0] a, b, got, pcIndex;
		logic [`DATA_WIDTH-1:0] expected [5];
		logic [11:0] imm;
		seqStateT st;
		int elapsed;
		beginTest("arithmetic, logic and HALT");
		a = $random(seed);
		b = $random(seed);
		imm = 12'($random(seed));
		expected = '{a + b, a - b, a & b, a | b, a + {20'b0, imm}};
		hostWrite(addrOf(REGION_DMEM, 0), a);
		hostWrite(addrOf(REGION_DMEM, 1), b);
		prog.push_back(ldur(5'd1, xzr, 9'd0));
		prog.push_back(ldur(5'd2, xzr, 9'd4));
		prog.push_back(rType(opAdd, 5'd3, 5'd1, 5'd2));
		prog.push_back(stur(5'd3, xzr, 9'd8));
		prog.push_back(rType(opSub, 5'd4, 5'd1, 5'd2));
		prog.push_back(stur(5'd4, xzr, 9'd12));
		prog.push_back(rType(opAnd, 5'd5, 5'd1, 5'd2));
		prog.push_back(stur(5'd5, xzr, 9'd16));
		prog.push_back(rType(opOrr, 5'd6, 5'd1, 5'd2));
		prog.push_back(stur(5'd6, xzr, 9'd20));
		prog.push_back(addi(5'd7, 5'd1, imm));
		prog.push_back(stur(5'd7, xzr, 9'd24));
		prog.push_back(haltWord);
		loadProgram();
		runUntilDone(st, pcIndex, elapsed);
		checkState("state after HALT", st, HALTED);
		checkWord("PC index at HALT", pcIndex, 32'd12);
		if (elapsed > 5 * prog.size()) begin
			failCheck($sformatf("halt took %0d cycles, more than 5 per instruction", elapsed));
		end
		for (int k = 0; k < 5; k++) begin
			hostRead(addrOf(REGION_DMEM, 2 + k), got);
			checkWord($sformatf("result word %0d", 2 + k), got, expected[k]);
		end
	endtask

	task automatic branchTest();
		logic [`DATA_WIDTH-1:0] got, pcIndex;
		seqStateT st;
		int elapsed;
		beginTest("branches");
		for (int w = 10; w < 16; w++) begin
			hostWrite(addrOf(REGION_DMEM, w), fillWord(w));
		end
		prog.push_back(addi(5'd9, xzr, 12'h5a5));
		prog.push_back(condBranch(1'b0, xzr, 19'd2)); // CBZ taken
		prog.push_back(stur(5'd9, xzr, 9'd40));
		prog.push_back(stur(5'd9, xzr, 9'd44));
		prog.push_back(condBranch(1'b1, 5'd9, 19'd2)); // CBNZ taken
		prog.push_back(stur(5'd9, xzr, 9'd48));
		prog.push_back(stur(5'd9, xzr, 9'd52));
		prog.push_back(branch(26'd2));
		prog.push_back(stur(5'd9, xzr, 9'd56));
		prog.push_back(stur(5'd9, xzr, 9'd60));
		prog.push_back(haltWord);
		loadProgram();
		runUntilDone(st, pcIndex, elapsed);
		checkState("state after branches", st, HALTED);
		checkWord("PC index at HALT", pcIndex, 32'd10);
		for (int w = 10; w < 16; w++) begin
			hostRead(addrOf(REGION_DMEM, w), got);
			checkWord($sformatf("branch word %0d", w), got, (w % 2 != 0) ? 32'h5a5 : fillWord(w));
		end
	endtask

	task automatic illegalTest();
		logic [`DATA_WIDTH-1:0] got, pcIndex;
		seqStateT st;
		int elapsed;
		beginTest("illegal opcode");
		hostWrite(addrOf(REGION_DMEM, 16), fillWord(16));
		prog.push_back(addi(5'd9, xzr, 12'h077));
		prog.push_back(32'h0000_0000); // No instruction matches
		prog.push_back(stur(5'd9, xzr, 9'd64));
		prog.push_back(haltWord);
		loadProgram();
		runUntilDone(st, pcIndex, elapsed);
		checkState("state after illegal word", st, FAULT);
		checkWord("PC index at fault", pcIndex, 32'd1);
		hostRead(addrOf(REGION_DMEM, 16), got);
		checkWord("word after illegal", got, fillWord(16));
	endtask

	task automatic apbRulesTest();
		logic [`DATA_WIDTH-1:0] got, pcIndex;
		logic err;
		seqStateT st;
		int elapsed;
		beginTest("APB rules");
		apbWrite(12'h008, 32'hFFFF_FFFF, err);
		checkErr("pSlvErr on unmapped write", err, 1'b1);
		apbRead(12'hC00, got, err);
		checkErr("pSlvErr on unmapped read", err, 1'b1);
		checkWord("unmapped read data", got, '0);
		hostWrite(addrOf(REGION_DMEM, 17), fillWord(17));
		prog.push_back(addi(5'd1, xzr, 12'd0));
		for (int k = 0; k < 40; k++) begin
			prog.push_back(addi(5'd1, 5'd1, 12'd1));
		end
		prog.push_back(stur(5'd1, xzr, 9'd72));
		prog.push_back(haltWord);
		loadProgram();
		startProgram();
		readState(st, pcIndex);
		checkState("state during long program", st, FETCH);
		apbWrite(addrOf(REGION_DMEM, 17), 32'h0, err);
		checkErr("pSlvErr on write while running", err, 1'b1);
		apbRead(addrOf(REGION_DMEM, 17), got, err);
		checkErr("pSlvErr on read while running", err, 1'b1);
		checkWord("read data while running", got, '0);
		waitDone(st, pcIndex, elapsed);
		checkState("state after long program", st, HALTED);
		hostRead(addrOf(REGION_DMEM, 17), got);
		checkWord("word written while running", got, fillWord(17));
		hostRead(addrOf(REGION_DMEM, 18), got);
		checkWord("counter result", got, 32'd40);
	endtask

	task automatic xzrTest();
		logic [`DATA_WIDTH-1:0] got, pcIndex;
		seqStateT st;
		int elapsed;
		beginTest("XZR");
		hostWrite(addrOf(REGION_DMEM, 19), fillWord(19));
		hostWrite(addrOf(REGION_DMEM, 20), fillWord(20));
		prog.push_back(addi(xzr, xzr, 12'h123));
		prog.push_back(stur(xzr, xzr, 9'd76));
		prog.push_back(addi(5'd4, xzr, 12'd5));
		prog.push_back(stur(5'd4, xzr, 9'd80));
		prog.push_back(haltWord);
		loadProgram();
		runUntilDone(st, pcIndex, elapsed);
		checkState("state after XZR program", st, HALTED);
		hostRead(addrOf(REGION_DMEM, 19), got);
		checkWord("store of XZR", got, '0);
		hostRead(addrOf(REGION_DMEM, 20), got);
		checkWord("XZR plus 5", got, 32'd5);
	endtask

	initial begin : watchdog
		while (cycleCount <= deadline) begin
			@(negedge clk);
		end
		$display("Timeout: no result within %0d clock cycles", deadline);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		repeat (4) @(negedge clk);
		rst = 1'b0;
		resetStatusTest();
		arithmeticTest();
		branchTest();
		illegalTest();
		apbRulesTest();
		xzrTest();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
